/* acCore.f */
logic/acPkg.sv
logic/programCounter.sv
logic/dataPath.sv
logic/memPort.sv
logic/controlUnit.sv
logic/acCore.sv
tests/acCore_props.sv
tests/acCore_tb.sv

/* tests/acCore_tb.sv */
`timescale 1ns/10ps

module acCore_tb;
	import acPkg::*;

	typedef logic [wordW-1:0] word_t;

	localparam int progLen  = 32;
	localparam int runLimit = 4000; // Cycles allowed for one program.
	localparam int numProgs = 4;

	logic    clk;
	logic    arstN;
	memReq_t iMem;
	memRsp_t iRsp;
	memReq_t dMem;
	memRsp_t dRsp;
	logic    busy;

	int      seed = 32'h16d7;
	bit      zeroDelay;
	int      errors;
	int      totalErrors;
	int      testsRun;
	int      testsFailed;
	int      iDelay;
	bit      iPending;
	int      dDelay;
	bit      dPending;
	word_t   imem [256];
	word_t   dmem [256];
	word_t   dinit [256];
	word_t   modelAcc;
	memReq_t expFetch [$];
	memReq_t expData [$];
	memReq_t stores [$];
	memReq_t storesRand [$];

	acCore u_acCore (
		.clk   (clk),
		.arstN (arstN),
		.iMem  (iMem),
		.iRsp  (iRsp),
		.dMem  (dMem),
		.dRsp  (dRsp),
		.busy  (busy)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ####################
	// Compare tasks.
	task automatic compareFetch(input memReq_t got, input memReq_t exp);
		if (got.write !== exp.write || got.addr !== exp.addr) begin
			$display("** Error: iMem write/addr got 0x%h/0x%h expected 0x%h/0x%h",
				got.write, got.addr, exp.write, exp.addr);
			errors++;
		end
	endtask

	task automatic compareAccess(input string sig, input memReq_t got, input memReq_t exp);
		if (got.write !== exp.write || got.addr !== exp.addr
				|| (exp.write && got.wdata !== exp.wdata)) begin
			$display("** Error: %s write/addr/wdata got 0x%h/0x%h/0x%h expected 0x%h/0x%h/0x%h",
				sig, got.write, got.addr, got.wdata, exp.write, exp.addr, exp.wdata);
			errors++;
		end
	endtask

	task automatic compareResult(input string sig, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%h expected 0x%h", sig, got, exp);
			errors++;
		end
	endtask

	task automatic takeFetch(input memReq_t got);
		if (expFetch.size() == 0) begin
			$display("Unexpected instruction read at 0x%h after the program ended", got.addr);
			errors++;
		end else begin
			compareFetch(got, expFetch.pop_front());
		end
	endtask

	task automatic takeAccess(input memReq_t got);
		if (expData.size() == 0) begin
			$display("Unexpected data access at 0x%h after the program ended", got.addr);
			errors++;
		end else begin
			compareAccess("dMem", got, expData.pop_front());
		end
		if (got.write) begin
			dmem[got.addr] = got.wdata;
			stores.push_back(got);
		end
	endtask

	function automatic int pickDelay();
		if (zeroDelay) begin
			return 0;
		end
		return $unsigned($random(seed)) % 4;
	endfunction

	// ####################
	// Memory models. Requests are seen and answered on the falling edge.
	always @(negedge clk) begin
		if (!arstN || iRsp.ack) begin
			iRsp     = '0;
			iPending = 1'b0;
		end else if (iMem.valid) begin
			if (!iPending) begin
				iPending = 1'b1;
				iDelay   = pickDelay();
				takeFetch(iMem);
			end
			if (iDelay == 0) begin
				iRsp.ack   = 1'b1;
				iRsp.rdata = imem[iMem.addr];
			end else begin
				iDelay--;
			end
		end
	end

	always @(negedge clk) begin
		if (!arstN || dRsp.ack) begin
			dRsp     = '0;
			dPending = 1'b0;
		end else if (dMem.valid) begin
			if (!dPending) begin
				dPending = 1'b1;
				dDelay   = pickDelay();
				takeAccess(dMem);
			end
			if (dDelay == 0) begin
				dRsp.ack   = 1'b1;
				dRsp.rdata = dmem[dMem.addr];
			end else begin
				dDelay--;
			end
		end
	end

	// ####################
	// Random program with forward jumps only, so every run reaches END.
	task automatic buildProgram();
		int      starts [$];
		int      pos;
		int      pick;
		opcode_t op;
		foreach (imem[a]) imem[a] = opEnd; // A stray fetch halts the core.
		foreach (dinit[a]) dinit[a] = word_t'($random(seed));
		pos = 0;
		while (pos < progLen - 2) begin
			op = opcode_t'(1 + $unsigned($random(seed)) % 10);
			starts.push_back(pos);
			imem[pos] = op;
			pos++;
			if (op inside {opLdAddr, opJmp, opJmpz}) begin
				imem[pos] = word_t'($random(seed));
				pos++;
			end
		end
		imem[pos] = opEnd;
		starts.push_back(pos);
		for (int k = 0; k < starts.size() - 1; k++) begin
			if (imem[starts[k]] inside {opJmp, opJmpz}) begin
				pick = k + 1 + $unsigned($random(seed)) % (starts.size() - 1 - k);
				imem[starts[k] + 1] = word_t'(starts[pick]);
			end
		end
	endtask

	// Reference model. Runs the program by the ISA and records the expected accesses.
	task automatic runModel();
		word_t   dm [256];
		word_t   pc;
		word_t   ar;
		word_t   mulr;
		word_t   op;
		int      steps;
		bit      halted;
		memReq_t req;
		dm       = dinit;
		pc       = '0;
		ar       = '0;
		mulr     = '0;
		modelAcc = '0;
		halted   = 1'b0;
		steps    = 0;
		req      = '0;
		req.valid = 1'b1;
		expFetch.delete();
		expData.delete();
		while (!halted && steps < 1000) begin
			req.write = 1'b0;
			req.wdata = '0;
			req.addr  = pc;
			expFetch.push_back(req);
			op = imem[pc];
			pc++;
			steps++;
			case (op)
				opRstAc: modelAcc = '0;
				opIncAc: modelAcc = modelAcc + 1'b1;
				opAdd:   modelAcc = modelAcc + ar;
				opMul:   modelAcc = modelAcc * mulr; // Low half only.
				opLdAddr: begin
					req.addr = pc;
					expFetch.push_back(req);
					ar = imem[pc];
					pc++;
				end
				opLdAc, opLdMulr: begin
					req.addr = ar;
					expData.push_back(req);
					if (op == opLdAc) begin
						modelAcc = dm[ar];
					end else begin
						mulr = dm[ar];
					end
				end
				opStAc: begin
					req.write = 1'b1;
					req.addr  = ar;
					req.wdata = modelAcc;
					expData.push_back(req);
					dm[ar] = modelAcc;
				end
				opJmp, opJmpz: begin
					if (op == opJmp || modelAcc == '0) begin
						req.addr = pc;
						expFetch.push_back(req);
						pc = imem[pc];
					end else begin
						pc++; // The untaken branch skips the target word.
					end
				end
				default: halted = 1'b1;
			endcase
		end
	endtask

	// ####################
	// Test sequencing.
	task automatic applyReset();
		@(negedge clk);
		arstN = 1'b0;
		repeat (5) @(negedge clk);
		arstN = 1'b1;
	endtask

	task automatic compareStores();
		if (stores.size() != storesRand.size()) begin
			$display("Zero delay run made %0d stores but the random delay run made %0d",
				stores.size(), storesRand.size());
			errors++;
		end else begin
			foreach (stores[k]) compareAccess("dMem store", stores[k], storesRand[k]);
		end
	endtask

	task automatic finishTest(input string name, input bit zeroWait, input int cycles);
		repeat (10) @(negedge clk); // Any request seen now came after END.
		if (expFetch.size() != 0 || expData.size() != 0) begin
			$display("%0d instruction reads and %0d data accesses of the model never happened",
				expFetch.size(), expData.size());
			errors++;
		end
		compareResult("acc", u_acCore.acc, modelAcc);
		if (zeroWait) begin
			compareStores();
		end
		testsRun++;
		totalErrors += errors;
		if (errors != 0) begin
			testsFailed++;
		end
		$display("%s: %s after %0d cycles, %0d errors", name, (errors == 0) ? "pass" : "FAIL",
			cycles, errors);
	endtask

	task automatic runTest(input string name, input bit zeroWait);
		int cycles;
		errors    = 0;
		zeroDelay = zeroWait;
		dmem      = dinit;
		stores.delete();
		runModel();
		applyReset();
		if (busy !== 1'b1) begin
			$display("busy is not high after reset");
			errors++;
		end
		cycles = 0;
		while (busy === 1'b1 && cycles < runLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (busy === 1'b1) begin
			$display("Timeout: %s still busy after %0d cycles", name, runLimit);
			$display("Something failed");
			$finish;
		end else begin
			finishTest(name, zeroWait, cycles);
		end
	endtask

	initial begin
		int propFails;
		arstN       = 1'b0;
		iRsp        = '0;
		dRsp        = '0;
		zeroDelay   = 1'b0;
		totalErrors = 0;
		testsRun    = 0;
		testsFailed = 0;
		for (int p = 0; p < numProgs; p++) begin
			buildProgram();
			runTest($sformatf("program %0d, random delays", p), 1'b0);
			storesRand = stores;
			runTest($sformatf("program %0d, zero delays", p), 1'b1);
		end
		propFails = u_acCore.u_memPort.u_handshakeProps.failures;
		$display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
			testsRun, testsFailed, totalErrors, propFails);
		if (totalErrors == 0 && propFails == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* tests/acCore_props.sv */
`timescale 1ns/10ps

module handshakeProps (
	input logic           clk,
	input logic           arstN,
	input acPkg::memReq_t iMem,
	input acPkg::memRsp_t iRsp,
	input acPkg::memReq_t dMem,
	input acPkg::memRsp_t dRsp
);

	int failures = 0;

	// ####################
	// A request stays up and unchanged until memory acknowledges it.
	iHold: assert property (@(posedge clk) disable iff (!arstN)
		iMem.valid && !iRsp.ack |=> iMem.valid && $stable(iMem.addr) && $stable(iMem.write))
		else begin
			$error("iMem request dropped or changed before ack");
			failures++;
		end

	dHold: assert property (@(posedge clk) disable iff (!arstN)
		dMem.valid && !dRsp.ack |=> dMem.valid && $stable(dMem.addr) && $stable(dMem.write)
			&& $stable(dMem.wdata))
		else begin
			$error("dMem request dropped or changed before ack");
			failures++;
		end

	// Only one access is in flight.
	oneActive: assert property (@(posedge clk) disable iff (!arstN)
		!(iMem.valid && dMem.valid))
		else begin
			$error("valid high on both memory ports together");
			failures++;
		end

	// The first command of the controller reaches memPort one cycle after reset ends.
	idleAfterReset: assert property (@(posedge clk)
		$rose(arstN) |-> (!iMem.valid && !dMem.valid) ##1 (!iMem.valid && !dMem.valid))
		else begin
			$error("memory request pending right after reset");
			failures++;
		end

endmodule

bind memPort handshakeProps u_handshakeProps (
	.clk   (clk),
	.arstN (arstN),
	.iMem  (iMem),
	.iRsp  (iRsp),
	.dMem  (dMem),
	.dRsp  (dRsp)
);

/* logic/acCore.sv */
`timescale 1ns/10ps

module acCore #(
	parameter int dataWidth = acPkg::wordW,
	parameter int addrWidth = acPkg::addrW
) (
	input  logic           clk,
	input  logic           arstN,
	output acPkg::memReq_t iMem,
	input  acPkg::memRsp_t iRsp,
	output acPkg::memReq_t dMem,
	input  acPkg::memRsp_t dRsp,
	output logic           busy
);
	import acPkg::*;

	ctrl_t                ctrl;
	logic                 memDone;
	logic [dataWidth-1:0] memWord; // Last word read from either memory.
	logic                 accZero;
	logic [addrWidth-1:0] pc;
	logic [dataWidth-1:0] acc;
	logic [dataWidth-1:0] addrReg;

	controlUnit u_controlUnit (
		.clk     (clk),
		.arstN   (arstN),
		.memDone (memDone),
		.memWord (memWord),
		.accZero (accZero),
		.ctrl    (ctrl),
		.busy    (busy)
	);

	programCounter #(
		.addrWidth (addrWidth)
	) u_programCounter (
		.clk     (clk),
		.arstN   (arstN),
		.ctrl    (ctrl),
		.memWord (memWord),
		.pc      (pc)
	);

	dataPath #(
		.dataWidth (dataWidth)
	) u_dataPath (
		.clk     (clk),
		.arstN   (arstN),
		.ctrl    (ctrl),
		.memWord (memWord),
		.acc     (acc),
		.addrReg (addrReg),
		.accZero (accZero)
	);

	memPort #(
		.dataWidth (dataWidth),
		.addrWidth (addrWidth)
	) u_memPort (
		.clk     (clk),
		.arstN   (arstN),
		.ctrl    (ctrl),
		.pc      (pc),
		.addrReg (addrReg),
		.acc     (acc),
		.iMem    (iMem),
		.iRsp    (iRsp),
		.dMem    (dMem),
		.dRsp    (dRsp),
		.memDone (memDone),
		.memWord (memWord)
	);

endmodule

/* logic/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    memDone,
	input  logic [acPkg::wordW-1:0] memWord,
	input  logic                    accZero,
	output acPkg::ctrl_t            ctrl,
	output logic                    busy
);
	import acPkg::*;

	// The control word is registered, so each action is active in the cycle
	// after the state that chose it.
	typedef enum logic [2:0] {
		sFetch,
		sFetchWait,
		sDecode,
		sExec,
		sMemWait,
		sEnd
	} state_t;

	state_t  state;
	state_t  stateNext;
	ctrl_t   ctrlNext;
	opcode_t ir;

	assign busy = (state != sEnd);

	// ####################
	// State and control registers.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= sFetch;
			ctrl  <= '0;
		end else begin
			state <= stateNext;
			ctrl  <= ctrlNext;
		end
	end

	// Instruction register, loaded when the fetch read completes.
	always_ff @(posedge clk) begin
		if (state == sFetchWait && memDone) begin
			ir <= opcode_t'(memWord);
		end
	end

	// ####################
	// Next state and next control word.
	always_comb begin
		stateNext = state;
		ctrlNext  = '0;
		case (state)
			sFetch: begin
				ctrlNext.memCmd = memIRead;
				stateNext       = sFetchWait;
			end

			sFetchWait: begin
				if (memDone) begin
					ctrlNext.pcInc = 1'b1; // The decode cycle steps pc.
					stateNext      = sDecode;
				end
			end

			sDecode: begin
				stateNext = sExec;
				case (ir)
					opRstAc:  ctrlNext.aluOp = aluClear;
					opIncAc:  ctrlNext.aluOp = aluInc;
					opAdd:    ctrlNext.aluOp = aluAdd;
					opMul:    ctrlNext.aluOp = aluMul;
					opLdAddr: ctrlNext.memCmd = memIRead; // Operand word follows the opcode.
					opJmp:    ctrlNext.memCmd = memIRead;
					opLdAc:   ctrlNext.memCmd = memDRead;
					opLdMulr: ctrlNext.memCmd = memDRead;
					opStAc:   ctrlNext.memCmd = memWrite;
					opJmpz: begin
						if (accZero) begin
							ctrlNext.memCmd = memIRead;
						end else begin
							ctrlNext.pcInc = 1'b1; // Skip the target word.
						end
					end
					default: stateNext = sEnd; // END and any unknown opcode.
				endcase
			end

			sExec: begin
				// A pending memory command sends us to wait for it.
				// Otherwise the instruction is complete and the next fetch goes out.
				if (ctrl.memCmd != memIdle) begin
					stateNext = sMemWait;
				end else begin
					ctrlNext.memCmd = memIRead;
					stateNext       = sFetchWait;
				end
			end

			sMemWait: begin
				if (memDone) begin
					stateNext = sFetch;
					case (ir)
						opLdAddr: begin
							ctrlNext.wrAddr = 1'b1;
							ctrlNext.pcInc  = 1'b1;
						end
						opLdAc:   ctrlNext.aluOp = aluLoad;
						opLdMulr: ctrlNext.wrMulr = 1'b1;
						opJmp:    ctrlNext.pcLoad = 1'b1;
						opJmpz:   ctrlNext.pcLoad = 1'b1;
						default:  ctrlNext = '0; // Store needs nothing more.
					endcase
				end
			end

			sEnd: stateNext = sEnd; // Held until reset.

			default: stateNext = sEnd;
		endcase
	end

endmodule

/* logic/memPort.sv */
`timescale 1ns/10ps

module memPort #(
	parameter int dataWidth = acPkg::wordW,
	parameter int addrWidth = acPkg::addrW
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  acPkg::ctrl_t         ctrl,
	input  logic [addrWidth-1:0] pc,
	input  logic [dataWidth-1:0] addrReg,
	input  logic [dataWidth-1:0] acc,
	output acPkg::memReq_t       iMem,
	input  acPkg::memRsp_t       iRsp,
	output acPkg::memReq_t       dMem,
	input  acPkg::memRsp_t       dRsp,
	output logic                 memDone,
	output logic [dataWidth-1:0] memWord
);
	import acPkg::*;

	localparam int iPort = 0;
	localparam int dPort = 1;

	memReq_t    req [2];
	memRsp_t    rsp [2];
	memReq_t    newReq;
	logic [1:0] start;
	logic [1:0] hit; // Held request meets its ack.

	assign iMem       = req[iPort];
	assign dMem       = req[dPort];
	assign rsp[iPort] = iRsp;
	assign rsp[dPort] = dRsp;

	assign hit[iPort] = req[iPort].valid & rsp[iPort].ack;
	assign hit[dPort] = req[dPort].valid & rsp[dPort].ack;

	// ####################
	// Request built from the one-cycle memory command.
	always_comb begin
		start        = '0;
		newReq       = '0;
		newReq.valid = 1'b1;
		case (ctrl.memCmd)
			memIRead: begin
				start[iPort] = 1'b1;
				newReq.addr  = addrW'(pc);
			end
			memDRead: begin
				start[dPort] = 1'b1;
				newReq.addr  = addrW'(addrReg);
			end
			memWrite: begin
				start[dPort] = 1'b1;
				newReq.write = 1'b1;
				newReq.addr  = addrW'(addrReg);
				newReq.wdata = wordW'(acc);
			end
			default: start = '0;
		endcase
	end

	// Each port holds its request until ack, then drops valid and reports done.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			req[iPort] <= '0;
			req[dPort] <= '0;
			memDone    <= 1'b0;
		end else begin
			memDone <= |hit;
			for (int i = 0; i < 2; i++) begin
				if (hit[i]) begin
					req[i].valid <= 1'b0;
				end else if (start[i]) begin
					req[i] <= newReq;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (hit[i] && !req[i].write) begin
				memWord <= dataWidth'(rsp[i].rdata); // Read data is valid in the ack cycle.
			end
		end
	end

endmodule

/* logic/dataPath.sv */
`timescale 1ns/10ps

module dataPath #(
	parameter int dataWidth = acPkg::wordW
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  acPkg::ctrl_t         ctrl,
	input  logic [dataWidth-1:0] memWord,
	output logic [dataWidth-1:0] acc,
	output logic [dataWidth-1:0] addrReg,
	output logic                 accZero
);
	import acPkg::*;

	typedef logic [dataWidth-1:0] word_t;

	word_t                  mulr;
	word_t                  accNext;
	logic [2*dataWidth-1:0] product;

	assign product = acc * mulr; // Full width product, low half is kept.

	// ####################
	// ALU.
	always_comb begin
		case (ctrl.aluOp)
			aluClear: accNext = '0;
			aluInc:   accNext = acc + 1'b1;
			aluLoad:  accNext = memWord;
			aluAdd:   accNext = acc + addrReg;
			aluMul:   accNext = product[dataWidth-1:0];
			default:  accNext = acc;
		endcase
	end

	assign accZero = (acc == '0);

	// ####################
	// Registers.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			acc <= '0;
		end else begin
			acc <= accNext;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			addrReg <= '0;
		end else if (ctrl.wrAddr) begin
			addrReg <= memWord;
		end
	end

	// Multiplier operand for MUL.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mulr <= '0;
		end else if (ctrl.wrMulr) begin
			mulr <= memWord;
		end
	end

endmodule

/* logic/programCounter.sv */
`timescale 1ns/10ps

module programCounter #(
	parameter int addrWidth = acPkg::addrW
) (
	input  logic                    clk,
	input  logic                    arstN,
	input  acPkg::ctrl_t            ctrl,
	input  logic [acPkg::wordW-1:0] memWord,
	output logic [addrWidth-1:0]    pc
);

	logic [addrWidth-1:0] target;

	// Jump target comes from the operand word just read.
	assign target = addrWidth'(memWord);

	// ####################
	// A load wins over an increment, though the controller never asks for both.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (ctrl.pcLoad) begin
			pc <= target;
		end else if (ctrl.pcInc) begin
			pc <= pc + 1'b1; // Wraps at the top of memory.
		end
	end

endmodule

/* logic/acPkg.sv */
package acPkg;

	localparam int wordW = 8; // Data and instruction word.
	localparam int addrW = 8; // Memory address.

	// ####################
	// Instruction set.
	typedef enum logic [wordW-1:0] {
		opEnd    = 0,
		opRstAc  = 1,
		opIncAc  = 2,
		opLdAddr = 3,
		opLdAc   = 4,
		opLdMulr = 5,
		opStAc   = 6,
		opAdd    = 7,
		opMul    = 8,
		opJmp    = 9,
		opJmpz   = 10
	} opcode_t;

	typedef enum logic [2:0] {aluNone, aluClear, aluInc, aluLoad, aluAdd, aluMul} aluOp_t;

	typedef enum logic [1:0] {memIdle, memIRead, memDRead, memWrite} memCmd_t;

	// ####################
	// Control word, one bit or field per datapath action.
	typedef struct packed {
		aluOp_t  aluOp;
		logic    wrAddr; // Address register takes the captured memory word.
		logic    wrMulr;
		logic    pcInc;
		logic    pcLoad;
		memCmd_t memCmd;
	} ctrl_t;

	typedef struct packed {
		logic             valid;
		logic             write;
		logic [addrW-1:0] addr;
		logic [wordW-1:0] wdata;
	} memReq_t;

	typedef struct packed {
		logic             ack;
		logic [wordW-1:0] rdata; // Valid in the ack cycle of a read.
	} memRsp_t;

endpackage
